// File: build.f
+incdir+dv
logic/udp_tx_cfg_pkg.sv
logic/eth_frame_pkg.sv
logic/udp_tx_fsm.sv
logic/nibble_timer.sv
logic/frame_builder.sv
logic/crc32_nibble.sv
logic/nibble_serializer.sv
logic/udp_tx_top.sv
dv/udp_tx_tb.sv

// File: Bender.yml
package:
  name: udp_tx

sources:
  - logic/udp_tx_cfg_pkg.sv
  - logic/eth_frame_pkg.sv
  - logic/udp_tx_fsm.sv
  - logic/nibble_timer.sv
  - logic/frame_builder.sv
  - logic/crc32_nibble.sv
  - logic/nibble_serializer.sv
  - logic/udp_tx_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/udp_tx_tb.sv

// File: dv/udp_tx_ref.svh
`ifndef UDP_TX_REF_SVH
`define UDP_TX_REF_SVH

// Everything that goes out with en high for one request
localparam int unsigned STREAM_NIBBLES = PREAMBLE_NIBBLES + FRAME_NIBBLES + FCS_NIBBLES;

// Element 0 is the first nibble on the wire
typedef logic [STREAM_NIBBLES-1:0][3:0] nibble_stream_t;

// Ones'-complement addition, the carry out wraps back into bit 0
function automatic logic [15:0] ones_add(input logic [15:0] a, input logic [15:0] b);
    logic [16:0] t;
    t = {1'b0, a} + {1'b0, b};
    return t[15:0] + {15'd0, t[16]};
endfunction

// Reflected CRC-32 advanced by one byte, one bit at a time, LSB first
function automatic logic [31:0] crc_add_byte(input logic [31:0] crc, input logic [7:0] data);
    logic [31:0] c;
    c = crc;
    for (int i = 0; i < 8; i++) begin
        c = (c[0] ^ data[i]) ? ((c >> 1) ^ CRC32_POLY_REFLECTED) : (c >> 1);
    end
    return c;
endfunction

// Expected nibble stream for a request and its payload
function automatic nibble_stream_t expected_stream(input udp_request_t req,
                                                   input logic [PAYLOAD_BYTES*8-1:0] pl);
    logic [7:0]     b [FRAME_BYTES];
    logic [15:0]    sum;
    logic [31:0]    crc;
    logic [31:0]    fcs;
    nibble_stream_t s;
    // Ethernet header, addresses sent MSB byte first
    for (int i = 0; i < 6; i++) begin
        b[i]     = req.dest_mac[47 - 8*i -: 8];
        b[6 + i] = req.src_mac[47 - 8*i -: 8];
    end
    b[12] = 8'h08;
    b[13] = 8'h00;
    // IPv4 header, total length is 20 + 8 + 18 = 46
    b[14] = {IP_VERSION, IP_IHL};
    b[15] = IP_TOS;
    b[16] = 8'h00;
    b[17] = 8'd46;
    // Identification, flags and fragment offset are all zero
    for (int i = 18; i < 22; i++) begin
        b[i] = 8'h00;
    end
    b[22] = IP_TTL;
    b[23] = IP_PROTO_UDP;
    b[24] = 8'h00;
    b[25] = 8'h00;
    for (int i = 0; i < 4; i++) begin
        b[26 + i] = req.src_ip[31 - 8*i -: 8];
        b[30 + i] = req.dest_ip[31 - 8*i -: 8];
    end
    // UDP header, length 8 + 18 = 26 and no checksum
    b[34] = req.src_port[15:8];
    b[35] = req.src_port[7:0];
    b[36] = req.dest_port[15:8];
    b[37] = req.dest_port[7:0];
    b[38] = 8'h00;
    b[39] = 8'd26;
    b[40] = 8'h00;
    b[41] = 8'h00;
    for (int i = 0; i < PAYLOAD_BYTES; i++) begin
        b[42 + i] = pl[PAYLOAD_BYTES*8 - 1 - 8*i -: 8];
    end
    // RFC 1071 checksum over the ten big-endian header words
    sum = 16'h0000;
    for (int w = 0; w < 10; w++) begin
        sum = ones_add(sum, {b[14 + 2*w], b[15 + 2*w]});
    end
    b[24] = ~sum[15:8];
    b[25] = ~sum[7:0];
    // Fifteen 5s then the D of the SFD
    for (int i = 0; i < 16; i++) begin
        s[i] = (i == 15) ? 4'hD : 4'h5;
    end
    // Frame bytes go low nibble first and feed the CRC as they go
    crc = 32'hFFFF_FFFF;
    for (int i = 0; i < FRAME_BYTES; i++) begin
        s[16 + 2*i] = b[i][3:0];
        s[17 + 2*i] = b[i][7:4];
        crc = crc_add_byte(crc, b[i]);
    end
    fcs = ~crc;
    for (int k = 0; k < 8; k++) begin
        s[136 + k] = fcs[4*k +: 4];
    end
    return s;
endfunction

`endif

// File: dv/udp_tx_tb.sv
module udp_tx_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import eth_frame_pkg::*;
    import udp_tx_cfg_pkg::*;

    `include "udp_tx_ref.svh"

    localparam logic [31:0] SEED            = 32'hf5fd;
    localparam int unsigned RANDOM_REQUESTS = 8;
    // Random frames, zero and ones payloads, the held send and a back-to-back pair
    localparam int unsigned TOTAL_REQUESTS  = RANDOM_REQUESTS + 5;
    localparam int unsigned TIMEOUT_CYCLES  = TOTAL_REQUESTS * (170 * NIBBLE_DIVIDER + 20);
    localparam int unsigned GAP_CYCLES      = GAP_NIBBLES * NIBBLE_DIVIDER;

    logic                       clk;
    logic                       reset;
    logic                       send;
    udp_request_t               request;
    logic [PAYLOAD_BYTES*8-1:0] payload;
    logic                       ready;
    mii_tx_t                    tx;

    nibble_stream_t expected;
    int unsigned    strobe_count = 0;
    int unsigned    since_strobe = 0;
    int unsigned    en_low_run   = 0;
    int unsigned    cycle_count  = 0;
    int unsigned    error_count  = 0;
    int unsigned    tests_run    = 0;
    int unsigned    tests_failed = 0;
    logic           seen_en      = 1'b0;
    logic           ready_prev   = 1'b1;

    udp_tx_top i_udp_tx_top (
        .clk     (clk),
        .reset   (reset),
        .send    (send),
        .request (request),
        .payload (payload),
        .ready   (ready),
        .tx      (tx)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Hard stop in case the DUT stalls
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run took more than %0d cycles", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // Samples the registered bus values just before each edge and compares them
    always @(posedge clk) begin
        if (!reset) begin
            if (tx.strobe) begin
                if (!tx.en) begin
                    $display("FAIL tx.en strobe %0d expected %h got %h",
                             strobe_count, 1'b1, tx.en);
                    error_count++;
                end
                if (strobe_count >= STREAM_NIBBLES) begin
                    $display("Strobe %0d came after the frame was complete", strobe_count);
                    error_count++;
                end else if (tx.d !== expected[strobe_count]) begin
                    $display("FAIL tx.d nibble %0d expected %h got %h",
                             strobe_count, expected[strobe_count], tx.d);
                    error_count++;
                end
                strobe_count++;
                since_strobe = 0;
            end else begin
                since_strobe++;
            end
            // A new frame must follow a full interframe gap
            if (tx.en) begin
                if (seen_en && en_low_run != 0 && en_low_run < GAP_CYCLES) begin
                    $display("Gap between frames was %0d cycles, at least %0d needed",
                             en_low_run, GAP_CYCLES);
                    error_count++;
                end
                seen_en    = 1'b1;
                en_low_run = 0;
            end else begin
                en_low_run++;
            end
            if (ready && !ready_prev && seen_en && since_strobe < GAP_CYCLES) begin
                $display("Ready came back %0d cycles after the last nibble, at least %0d needed",
                         since_strobe, GAP_CYCLES);
                error_count++;
            end
            ready_prev = ready;
        end
    end

    function automatic udp_request_t random_request();
        udp_request_t r;
        r.src_ip    = $urandom();
        r.src_mac   = {16'($urandom()), 32'($urandom())};
        r.src_port  = 16'($urandom());
        r.dest_ip   = $urandom();
        r.dest_mac  = {16'($urandom()), 32'($urandom())};
        r.dest_port = 16'($urandom());
        return r;
    endfunction

    function automatic logic [PAYLOAD_BYTES*8-1:0] random_payload();
        logic [PAYLOAD_BYTES*8-1:0] p;
        for (int i = 0; i < PAYLOAD_BYTES; i++) begin
            p[i*8 +: 8] = 8'($urandom());
        end
        return p;
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s expected %h got %h", name, exp, got);
            error_count++;
        end
    endtask

    // Starts at 5 ns past an edge with ready high and returns the same way
    task automatic run_frame(input udp_request_t req, input logic [PAYLOAD_BYTES*8-1:0] pl,
                             input logic hold_send);
        expected     = expected_stream(req, pl);
        strobe_count = 0;
        request      = req;
        payload      = pl;
        send         = 1'b1;
        @(posedge clk);
        #5;
        check_bit("ready", ready, 1'b0);
        send    = hold_send;
        // Fresh values after accept must not reach the frame
        request = random_request();
        payload = random_payload();
        do begin
            @(posedge clk);
            #5;
            // Let go of send once the frame is out and the gap has begun
            if (hold_send && !tx.en && strobe_count == STREAM_NIBBLES) begin
                send = 1'b0;
            end
        end while (!ready);
        if (strobe_count != STREAM_NIBBLES) begin
            $display("Frame ended after %0d strobes instead of %0d",
                     strobe_count, STREAM_NIBBLES);
            error_count++;
        end
    endtask

    task automatic finish_test(input string name, input int unsigned errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: %0d checks failed", name, error_count - errors_before);
        end
    endtask

    initial begin
        int unsigned errors_before;
        void'($urandom(SEED));
        reset   = 1'b1;
        send    = 1'b0;
        request = '0;
        payload = '0;
        expected = '0;
        repeat (2) @(posedge clk);
        #5;
        reset = 1'b0;

        errors_before = error_count;
        repeat (3) begin
            check_bit("ready", ready, 1'b1);
            check_bit("tx.en", tx.en, 1'b0);
            check_bit("tx.strobe", tx.strobe, 1'b0);
            @(posedge clk);
            #5;
        end
        finish_test("reset state", errors_before);

        for (int n = 0; n < RANDOM_REQUESTS; n++) begin
            errors_before = error_count;
            run_frame(random_request(), random_payload(), 1'b0);
            finish_test($sformatf("random request %0d", n), errors_before);
        end

        errors_before = error_count;
        run_frame(random_request(), '0, 1'b0);
        finish_test("all-zero payload", errors_before);

        errors_before = error_count;
        run_frame(random_request(), '1, 1'b0);
        finish_test("all-ones payload", errors_before);

        // Send stays high through the frame and must not start another one
        errors_before = error_count;
        run_frame(random_request(), random_payload(), 1'b1);
        finish_test("send held during frame", errors_before);

        // Second request goes in on the first cycle ready is back
        errors_before = error_count;
        run_frame(random_request(), random_payload(), 1'b0);
        run_frame(random_request(), random_payload(), 1'b0);
        finish_test("back-to-back requests", errors_before);

        $display("Tests run %0d, tests failed %0d, checks failed %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: logic/udp_tx_top.sv
module udp_tx_top (
    input  logic                                       clk,
    input  logic                                       reset,
    input  logic                                       send,
    input  udp_tx_cfg_pkg::udp_request_t               request,
    input  logic [udp_tx_cfg_pkg::PAYLOAD_BYTES*8-1:0] payload,
    output logic                                       ready,
    output udp_tx_cfg_pkg::mii_tx_t                    tx
);
    import eth_frame_pkg::*;
    import udp_tx_cfg_pkg::*;

    tx_phase_e   phase;
    logic        tick;
    logic        phase_last;
    nibble_idx_t nibble_idx;
    frame_t      frame;
    logic [31:0] crc;

    // Phase sequencing and the ready handshake
    udp_tx_fsm i_udp_tx_fsm (
        .clk        (clk),
        .reset      (reset),
        .send       (send),
        .tick       (tick),
        .phase_last (phase_last),
        .ready      (ready),
        .phase      (phase)
    );

    // Nibble strobe and position within the current phase
    nibble_timer i_nibble_timer (
        .clk        (clk),
        .reset      (reset),
        .phase      (phase),
        .tick       (tick),
        .nibble_idx (nibble_idx),
        .phase_last (phase_last)
    );

    frame_builder i_frame_builder (
        .clk     (clk),
        .reset   (reset),
        .phase   (phase),
        .request (request),
        .payload (payload),
        .frame   (frame)
    );

    crc32_nibble i_crc32_nibble (
        .clk        (clk),
        .reset      (reset),
        .phase      (phase),
        .tick       (tick),
        .frame      (frame),
        .nibble_idx (nibble_idx),
        .crc        (crc)
    );

    // Drives the MII transmit bus
    nibble_serializer i_nibble_serializer (
        .clk        (clk),
        .reset      (reset),
        .phase      (phase),
        .tick       (tick),
        .nibble_idx (nibble_idx),
        .frame      (frame),
        .crc        (crc),
        .tx         (tx)
    );

endmodule

// File: logic/nibble_serializer.sv
module nibble_serializer (
    input  logic                        clk,
    input  logic                        reset,
    input  udp_tx_cfg_pkg::tx_phase_e   phase,
    input  logic                        tick,
    input  udp_tx_cfg_pkg::nibble_idx_t nibble_idx,
    input  eth_frame_pkg::frame_t       frame,
    input  logic [31:0]                 crc,
    output udp_tx_cfg_pkg::mii_tx_t     tx
);
    import eth_frame_pkg::*;
    import udp_tx_cfg_pkg::*;

    logic            sending;
    logic [3:0]      nibble;
    logic [7:0][3:0] fcs_nibbles;

    // Preamble, frame and FCS all drive the bus, the gap does not
    assign sending = (phase == PHASE_PREAMBLE) || (phase == PHASE_FRAME) ||
                     (phase == PHASE_FCS);

    // FCS is the complemented remainder, element 0 holds the bits that go first
    assign fcs_nibbles = ~crc;

    always_comb begin
        case (phase)
            PHASE_PREAMBLE: begin
                // The SFD's high nibble replaces the last preamble nibble
                nibble = (nibble_idx == nibble_idx_t'(PREAMBLE_NIBBLES - 1)) ?
                         SFD_LAST_NIBBLE : PREAMBLE_NIBBLE;
            end
            PHASE_FRAME: nibble = frame_nibble(frame, nibble_idx);
            PHASE_FCS:   nibble = fcs_nibbles[nibble_idx[2:0]];
            default:     nibble = '0;
        endcase
    end

    // Bus changes one cycle after the tick and holds until the next one
    always_ff @(posedge clk) begin
        if (reset) begin
            tx <= '0;
        end else begin
            tx.strobe <= tick && sending;
            if (tick) begin
                tx.en <= sending;
                tx.d  <= nibble;
            end
        end
    end

endmodule

// File: logic/crc32_nibble.sv
module crc32_nibble (
    input  logic                        clk,
    input  logic                        reset,
    input  udp_tx_cfg_pkg::tx_phase_e   phase,
    input  logic                        tick,
    input  eth_frame_pkg::frame_t       frame,
    input  udp_tx_cfg_pkg::nibble_idx_t nibble_idx,
    output logic [31:0]                 crc
);
    import eth_frame_pkg::*;
    import udp_tx_cfg_pkg::*;

    logic [3:0] nibble;

    // One entry of the reflected table: four single-bit LFSR shifts of the index
    function automatic logic [31:0] crc_table(input logic [3:0] index);
        logic [31:0] r;
        r = 32'(index);
        for (int b = 0; b < 4; b++) begin
            r = r[0] ? ((r >> 1) ^ CRC32_POLY_REFLECTED) : (r >> 1);
        end
        return r;
    endfunction

    // Same nibble that the serializer is putting on the wire for this tick
    assign nibble = frame_nibble(frame, nibble_idx);

    always_ff @(posedge clk) begin
        if (reset) begin
            crc <= '1;
        end else if (phase == PHASE_BUILD) begin
            // Preset for the new frame
            crc <= '1;
        end else if (phase == PHASE_FRAME && tick) begin
            // Bits are taken LSB first, so the low four bits of the state meet the nibble
            crc <= (crc >> 4) ^ crc_table(crc[3:0] ^ nibble);
        end
    end

endmodule

// File: logic/frame_builder.sv
module frame_builder (
    input  logic                                       clk,
    input  logic                                       reset,
    input  udp_tx_cfg_pkg::tx_phase_e                  phase,
    input  udp_tx_cfg_pkg::udp_request_t               request,
    input  logic [udp_tx_cfg_pkg::PAYLOAD_BYTES*8-1:0] payload,
    output eth_frame_pkg::frame_t                      frame
);
    import eth_frame_pkg::*;
    import udp_tx_cfg_pkg::*;

    logic [19:0] ip_sum;
    logic [16:0] ip_sum_fold;
    logic [15:0] ip_sum_final;
    logic [15:0] ip_checksum;

    // RFC 1071 sum of the ten header words, carries folded back in twice
    always_comb begin
        ip_sum = '0;
        for (int w = 0; w < 10; w++) begin
            ip_sum = ip_sum + 20'(frame.ip.ip_words[w]);
        end
        ip_sum_fold  = {1'b0, ip_sum[15:0]} + 17'(ip_sum[19:16]);
        ip_sum_final = ip_sum_fold[15:0] + 16'(ip_sum_fold[16]);
        ip_checksum  = ~ip_sum_final;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            frame <= '0;
        end else begin
            case (phase)
                // Track the inputs while idle
                // The last load lands on the accept edge, which is when the sender's values count
                PHASE_IDLE: begin
                    frame.eth.dest_mac  <= request.dest_mac;
                    frame.eth.src_mac   <= request.src_mac;
                    frame.ip.hdr.src_ip  <= request.src_ip;
                    frame.ip.hdr.dest_ip <= request.dest_ip;
                    frame.udp.src_port  <= request.src_port;
                    frame.udp.dest_port <= request.dest_port;
                    frame.payload       <= payload;
                end
                // Fixed protocol fields, checksum zeroed so it drops out of the sum
                PHASE_BUILD: begin
                    frame.eth.ether_type         <= ETHER_TYPE_IPV4;
                    frame.ip.hdr.version         <= IP_VERSION;
                    frame.ip.hdr.ihl             <= IP_IHL;
                    frame.ip.hdr.type_of_service <= IP_TOS;
                    frame.ip.hdr.total_length    <=
                        16'(IP_HEADER_BYTES + UDP_HEADER_BYTES + PAYLOAD_BYTES);
                    frame.ip.hdr.identification  <= '0;
                    frame.ip.hdr.flags           <= '0;
                    frame.ip.hdr.fragment_offset <= '0;
                    frame.ip.hdr.time_to_live    <= IP_TTL;
                    frame.ip.hdr.protocol        <= IP_PROTO_UDP;
                    frame.ip.hdr.header_checksum <= '0;
                    frame.udp.length   <= 16'(UDP_HEADER_BYTES + PAYLOAD_BYTES);
                    // No UDP checksum is sent
                    frame.udp.checksum <= '0;
                end
                PHASE_CHECKSUM: begin
                    frame.ip.hdr.header_checksum <= ip_checksum;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// File: logic/nibble_timer.sv
module nibble_timer (
    input  logic                        clk,
    input  logic                        reset,
    input  udp_tx_cfg_pkg::tx_phase_e   phase,
    output logic                        tick,
    output udp_tx_cfg_pkg::nibble_idx_t nibble_idx,
    output logic                        phase_last
);
    import udp_tx_cfg_pkg::*;

    div_count_t  div_cnt;
    logic        div_wrap;
    logic        timed;
    nibble_idx_t last_idx;

    // Nibbles in each timed phase, zero for the phases that are not timed
    function automatic int unsigned phase_length(tx_phase_e p);
        case (p)
            PHASE_PREAMBLE: return PREAMBLE_NIBBLES;
            PHASE_FRAME:    return FRAME_NIBBLES;
            PHASE_FCS:      return FCS_NIBBLES;
            PHASE_GAP:      return GAP_NIBBLES;
            default:        return 0;
        endcase
    endfunction

    assign div_wrap = (div_cnt == div_count_t'(NIBBLE_DIVIDER - 1));
    assign timed    = (phase_length(phase) != 0);
    assign last_idx = nibble_idx_t'(phase_length(phase) - 1);

    // The tick that carries the final nibble of this phase
    assign phase_last = tick && timed && (nibble_idx == last_idx);

    // Free-running divider, the strobe does not restart with a request
    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else begin
            div_cnt <= div_wrap ? '0 : div_cnt + 1'b1;
            tick    <= div_wrap;
        end
    end

    // Idx held at zero outside the timed phases, and wraps to zero at the end of each one
    always_ff @(posedge clk) begin
        if (reset) begin
            nibble_idx <= '0;
        end else if (!timed) begin
            nibble_idx <= '0;
        end else if (tick) begin
            nibble_idx <= phase_last ? '0 : nibble_idx + 1'b1;
        end
    end

endmodule

// File: logic/udp_tx_fsm.sv
module udp_tx_fsm (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      send,
    input  logic                      tick,
    input  logic                      phase_last,
    output logic                      ready,
    output udp_tx_cfg_pkg::tx_phase_e phase
);
    import udp_tx_cfg_pkg::*;

    tx_phase_e phase_next;
    logic      accept;
    logic      phase_done;

    // A request is taken only while idle and ready
    assign accept = send && ready;

    // The timed phases end on the strobe that carries their last nibble
    assign phase_done = tick && phase_last;

    always_comb begin
        phase_next = phase;
        case (phase)
            PHASE_IDLE: begin
                if (accept) begin
                    phase_next = PHASE_BUILD;
                end
            end
            // Header fields go in during this cycle
            PHASE_BUILD: begin
                phase_next = PHASE_CHECKSUM;
            end
            // IP checksum is written here, then we wait for the next tick
            PHASE_CHECKSUM: begin
                phase_next = PHASE_PREAMBLE;
            end
            PHASE_PREAMBLE: begin
                if (phase_done) begin
                    phase_next = PHASE_FRAME;
                end
            end
            PHASE_FRAME: begin
                if (phase_done) begin
                    phase_next = PHASE_FCS;
                end
            end
            PHASE_FCS: begin
                if (phase_done) begin
                    phase_next = PHASE_GAP;
                end
            end
            PHASE_GAP: begin
                if (phase_done) begin
                    phase_next = PHASE_IDLE;
                end
            end
            default: begin
                phase_next = PHASE_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= PHASE_IDLE;
            ready <= 1'b1;
        end else begin
            phase <= phase_next;
            // Drops the cycle after accept and rises on the way back into IDLE
            ready <= (phase_next == PHASE_IDLE);
        end
    end

endmodule

// File: logic/eth_frame_pkg.sv
package eth_frame_pkg;

    // Wire formats of the Ethernet, IPv4 and UDP headers
    // Every struct lists its fields in the order they go out on the wire
    // The first byte sits in the most significant position

    // Ethernet II header without preamble and FCS
    typedef struct packed {
        logic [47:0] dest_mac;
        logic [47:0] src_mac;
        logic [15:0] ether_type;
    } eth_header_t;

    // RFC 791 header with no options, so IHL is always five words
    typedef struct packed {
        logic [3:0]  version;
        logic [3:0]  ihl;
        logic [7:0]  type_of_service;
        logic [15:0] total_length;
        logic [15:0] identification;
        logic [2:0]  flags;
        logic [12:0] fragment_offset;
        logic [7:0]  time_to_live;
        logic [7:0]  protocol;
        logic [15:0] header_checksum;
        logic [31:0] src_ip;
        logic [31:0] dest_ip;
    } ip_header_t;

    // The same 160 bits seen as fields or as the ten words the checksum adds up
    typedef union packed {
        ip_header_t       hdr;
        logic [9:0][15:0] ip_words;
    } ip_header_u;

    // RFC 768 header
    typedef struct packed {
        logic [15:0] src_port;
        logic [15:0] dest_port;
        logic [15:0] length;
        logic [15:0] checksum;
    } udp_header_t;

    // The whole frame between SFD and FCS
    typedef struct packed {
        eth_header_t eth;
        ip_header_u  ip;
        udp_header_t udp;
        logic [udp_tx_cfg_pkg::PAYLOAD_BYTES*8-1:0] payload;
    } frame_t;

    localparam logic [15:0] ETHER_TYPE_IPV4      = 16'h0800;
    localparam logic [3:0]  IP_VERSION           = 4'd4;
    localparam logic [3:0]  IP_IHL               = 4'd5;
    // Asks for high throughput and high reliability
    localparam logic [7:0]  IP_TOS               = 8'h0C;
    localparam logic [7:0]  IP_TTL               = 8'hFF;
    localparam logic [7:0]  IP_PROTO_UDP         = 8'h11;
    localparam logic [31:0] CRC32_POLY_REFLECTED = 32'hEDB88320;

    localparam int unsigned ETH_HEADER_BYTES = 14;
    localparam int unsigned IP_HEADER_BYTES  = 20;
    localparam int unsigned UDP_HEADER_BYTES = 8;

    // Preamble bytes are 8'h55 and the SFD is 8'hD5, low nibble first
    localparam logic [3:0] PREAMBLE_NIBBLE = 4'h5;
    localparam logic [3:0] SFD_LAST_NIBBLE = 4'hD;

    // Nibble idx of the frame in MII order
    // Byte idx/2 counted from the first byte, low nibble on even idx
    function automatic logic [3:0] frame_nibble(frame_t frame, udp_tx_cfg_pkg::nibble_idx_t idx);
        logic [7:0] octet;
        octet = frame[(udp_tx_cfg_pkg::FRAME_BYTES - 1 - int'(idx[6:1])) * 8 +: 8];
        return idx[0] ? octet[7:4] : octet[3:0];
    endfunction

endpackage

// File: logic/udp_tx_cfg_pkg.sv
package udp_tx_cfg_pkg;

    // Fixed payload, large enough that the frame needs no padding
    localparam int unsigned PAYLOAD_BYTES = 18;

    // Ethernet, IP and UDP headers plus the payload, before the FCS
    localparam int unsigned FRAME_BYTES = 60;

    // Length of every timed phase, counted in nibble strobes
    localparam int unsigned PREAMBLE_NIBBLES = 16;
    localparam int unsigned FRAME_NIBBLES    = 2 * FRAME_BYTES;
    localparam int unsigned FCS_NIBBLES      = 8;
    // Twelve byte times of interframe gap
    localparam int unsigned GAP_NIBBLES      = 24;

    // Clock cycles per MII nibble
    localparam int unsigned NIBBLE_DIVIDER = 4;

    typedef logic [6:0] nibble_idx_t;
    typedef logic [$clog2(NIBBLE_DIVIDER)-1:0] div_count_t;

    typedef enum logic [2:0] {
        PHASE_IDLE,
        PHASE_BUILD,
        PHASE_CHECKSUM,
        PHASE_PREAMBLE,
        PHASE_FRAME,
        PHASE_FCS,
        PHASE_GAP
    } tx_phase_e;

    // Addressing of one datagram, both ends
    typedef struct packed {
        logic [31:0] src_ip;
        logic [47:0] src_mac;
        logic [15:0] src_port;
        logic [31:0] dest_ip;
        logic [47:0] dest_mac;
        logic [15:0] dest_port;
    } udp_request_t;

    // MII transmit side, strobe marks the cycle a new nibble is presented
    typedef struct packed {
        logic       en;
        logic       strobe;
        logic [3:0] d;
    } mii_tx_t;

endpackage
